/* hdl/rv_data_mem_config.svh */
`ifndef RV_DATA_MEM_CONFIG_SVH
`define RV_DATA_MEM_CONFIG_SVH

// Data RAM size in 32-bit words (4 kB)
`define RV_DMEM_WORDS 1024

// Width of the word address into the RAM lanes
`define RV_DMEM_ADDR_W 10

// Word addresses (byte address bits 31:2) of the memory-mapped registers
`define RV_LEDS_ADDR 30'h3FFF_FFFF
`define RV_MICROS_ADDR 30'h3FFF_FFFD

// Core clock, sets the microsecond prescale
`define RV_CLK_FREQ_HZ 250000000

// Width of the PWM counter and of each duty value
`define RV_PWM_W 8

`endif

/* hdl/mem_access_pkg.sv */
`default_nettype none

package mem_access_pkg;

    // RV32I load/store width codes, stores ignore bit 2
    typedef enum logic [2:0] {
        F3_BYTE   = 3'b000,
        F3_HALF   = 3'b001,
        F3_WORD   = 3'b010,
        F3_BYTE_U = 3'b100,
        F3_HALF_U = 3'b101
    } mem_funct3_e;

    typedef enum logic [1:0] {
        REGION_RAM    = 2'd0,
        REGION_LEDS   = 2'd1,
        REGION_MICROS = 2'd2,
        REGION_NONE   = 2'd3
    } mem_region_e;

    typedef struct packed {
        logic        we;
        mem_funct3_e funct3;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    // Byte enables and data already steered into their lanes
    typedef struct packed {
        logic [3:0]  be;
        logic [31:0] data;
    } lane_write_t;

    typedef struct packed {
        mem_funct3_e funct3;
        logic [1:0]  offset;
        mem_region_e region;
    } load_ctrl_t;

endpackage

`default_nettype wire

/* hdl/periph_pkg.sv */
`default_nettype none

package periph_pkg;

    // LED duty register layout, byte 0 at the lowest address is blue
    typedef struct packed {
        logic [7:0] led;
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } led_duty_t;

    typedef struct packed {
        logic led;
        logic red;
        logic green;
        logic blue;
    } pwm_out_t;

endpackage

`default_nettype wire

/* hdl/store_align.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_data_mem_config.svh"

module store_align (
    input  mem_access_pkg::mem_req_t    req,
    output mem_access_pkg::mem_region_e region,
    output mem_access_pkg::lane_write_t lane_wr,
    output mem_access_pkg::load_ctrl_t  load_ctrl
);

    logic       store_en;
    logic [3:0] lane_sel;

    // The peripheral words are checked first, everything else below 4 kB is RAM
    always_comb begin
        if (req.addr[31:2] == `RV_LEDS_ADDR) begin
            region = mem_access_pkg::REGION_LEDS;
        end else if (req.addr[31:2] == `RV_MICROS_ADDR) begin
            region = mem_access_pkg::REGION_MICROS;
        end else if (req.addr[31:2] < 30'(`RV_DMEM_WORDS)) begin
            region = mem_access_pkg::REGION_RAM;
        end else begin
            region = mem_access_pkg::REGION_NONE;
        end
    end

    // Only the RAM and the LED register accept writes
    assign store_en = req.we && (region == mem_access_pkg::REGION_RAM ||
                                 region == mem_access_pkg::REGION_LEDS);

    // Narrow data is replicated across the word so every lane sees its bytes
    always_comb begin
        case (req.funct3)
            mem_access_pkg::F3_WORD: begin
                lane_sel     = 4'b1111;
                lane_wr.data = req.wdata;
            end
            mem_access_pkg::F3_HALF, mem_access_pkg::F3_HALF_U: begin
                lane_sel     = req.addr[1] ? 4'b1100 : 4'b0011;
                lane_wr.data = {2{req.wdata[15:0]}};
            end
            default: begin
                lane_sel     = 4'b0001 << req.addr[1:0];
                lane_wr.data = {4{req.wdata[7:0]}};
            end
        endcase
        lane_wr.be = store_en ? lane_sel : 4'b0000;
    end

    assign load_ctrl = '{funct3: req.funct3, offset: req.addr[1:0], region: region};

endmodule

`default_nettype wire

/* hdl/byte_lane_ram.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_data_mem_config.svh"

module byte_lane_ram (
    input  wire logic                        clk,
    input  mem_access_pkg::lane_write_t      lane_wr,
    input  wire logic [`RV_DMEM_ADDR_W-1:0]  word_addr,
    output logic [31:0]                      rdata
);

    // One byte-wide array per lane, all addressed by the same word address
    for (genvar lane = 0; lane < 4; lane++) begin : g_lane
        logic [7:0] mem [`RV_DMEM_WORDS];
        logic [7:0] q;

        // A lane being written keeps its previous read value
        always_ff @(posedge clk) begin
            if (lane_wr.be[lane]) begin
                mem[word_addr] <= lane_wr.data[8*lane +: 8];
            end else begin
                q <= mem[word_addr];
            end
        end

        assign rdata[8*lane +: 8] = q;
    end

endmodule

`default_nettype wire

/* hdl/periph_regs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_data_mem_config.svh"

module periph_regs (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  mem_access_pkg::mem_region_e region,
    input  mem_access_pkg::lane_write_t lane_wr,
    output periph_pkg::pwm_out_t        pwm,
    output logic [31:0]                 periph_rdata
);

    localparam int unsigned TICKS_PER_US = `RV_CLK_FREQ_HZ / 1000000;
    localparam int PRESC_W = (TICKS_PER_US > 1) ? $clog2(TICKS_PER_US) : 1;

    periph_pkg::led_duty_t leds;
    logic [31:0]           lane_mask;
    logic [`RV_PWM_W-1:0]  pwm_cnt;
    logic [PRESC_W-1:0]    presc;
    logic [31:0]           micros;

    for (genvar i = 0; i < 4; i++) begin : g_mask
        assign lane_mask[8*i +: 8] = {8{lane_wr.be[i]}};
    end

    // Byte-enabled update of the duty register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            leds <= '0;
        end else if (region == mem_access_pkg::REGION_LEDS) begin
            leds <= (leds & ~lane_mask) | (lane_wr.data & lane_mask);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
        end
    end

    // Each output is high while the counter is below its duty
    assign pwm = '{led:   pwm_cnt < leds.led,
                   red:   pwm_cnt < leds.red,
                   green: pwm_cnt < leds.green,
                   blue:  pwm_cnt < leds.blue};

    // Microsecond timer, wraps at 2^32
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc  <= '0;
            micros <= '0;
        end else if (presc == PRESC_W'(TICKS_PER_US - 1)) begin
            presc  <= '0;
            micros <= micros + 32'd1;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        case (region)
            mem_access_pkg::REGION_LEDS:   periph_rdata <= leds;
            mem_access_pkg::REGION_MICROS: periph_rdata <= micros;
            default:                       periph_rdata <= 32'd0;
        endcase
    end

    a_presc_limit: assert property (@(posedge clk) disable iff (!rst_n)
        32'(presc) < TICKS_PER_US)
        else $error("Microsecond prescaler reached its limit");

endmodule

`default_nettype wire

/* hdl/load_extend.sv */
`timescale 1ns/100ps
`default_nettype none

module load_extend (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  mem_access_pkg::load_ctrl_t load_ctrl,
    input  wire logic [31:0]           ram_rdata,
    input  wire logic [31:0]           periph_rdata,
    output logic [31:0]                rdata
);

    mem_access_pkg::load_ctrl_t ctrl_q;
    logic [31:0]                word;
    logic [15:0]                half_sel;
    logic [7:0]                 byte_sel;

    // Controls follow the data into the read cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q <= load_ctrl;
        end
    end

    // Peripheral word is already zero for unmapped addresses
    assign word = (ctrl_q.region == mem_access_pkg::REGION_RAM) ? ram_rdata : periph_rdata;

    assign half_sel = ctrl_q.offset[1] ? word[31:16] : word[15:0];
    assign byte_sel = word[8*ctrl_q.offset +: 8];

    always_comb begin
        case (ctrl_q.funct3)
            mem_access_pkg::F3_HALF:   rdata = {{16{half_sel[15]}}, half_sel};
            mem_access_pkg::F3_HALF_U: rdata = {16'd0, half_sel};
            mem_access_pkg::F3_BYTE:   rdata = {{24{byte_sel[7]}}, byte_sel};
            mem_access_pkg::F3_BYTE_U: rdata = {24'd0, byte_sel};
            default:                   rdata = word;
        endcase
    end

    // The core only issues the five RV32I load widths
    a_legal_funct3: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_q.funct3 inside {mem_access_pkg::F3_BYTE, mem_access_pkg::F3_HALF,
                              mem_access_pkg::F3_WORD, mem_access_pkg::F3_BYTE_U,
                              mem_access_pkg::F3_HALF_U})
        else $error("Illegal load funct3 %b", ctrl_q.funct3);

endmodule

`default_nettype wire

/* hdl/rv_data_mem.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_data_mem_config.svh"

module rv_data_mem (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  mem_access_pkg::mem_req_t req,
    output logic [31:0]              rdata,
    output periph_pkg::pwm_out_t     pwm
);

    mem_access_pkg::mem_region_e region;
    mem_access_pkg::lane_write_t lane_wr;
    mem_access_pkg::load_ctrl_t  load_ctrl;
    logic [31:0]                 ram_rdata;
    logic [31:0]                 periph_rdata;

    store_align u_store_align (
        .req       (req),
        .region    (region),
        .lane_wr   (lane_wr),
        .load_ctrl (load_ctrl)
    );

    byte_lane_ram u_ram (
        .clk       (clk),
        .lane_wr   (lane_wr),
        .word_addr (req.addr[`RV_DMEM_ADDR_W+1:2]),
        .rdata     (ram_rdata)
    );

    periph_regs u_periph (
        .clk          (clk),
        .rst_n        (rst_n),
        .region       (region),
        .lane_wr      (lane_wr),
        .pwm          (pwm),
        .periph_rdata (periph_rdata)
    );

    load_extend u_load_extend (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_ctrl    (load_ctrl),
        .ram_rdata    (ram_rdata),
        .periph_rdata (periph_rdata),
        .rdata        (rdata)
    );

endmodule

`default_nettype wire

/* verif/rv_data_mem_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_data_mem_config.svh"

module rv_data_mem_tb;

    localparam int N_WORD = 64;
    localparam int N_NARROW = 16;
    localparam int PWM_WIN = 256;
    localparam int TIMER_K = 4;
    localparam int TICKS_PER_US = `RV_CLK_FREQ_HZ / 1000000;
    localparam int MAX_CYCLES = 5 + 2 * N_WORD + 17 * N_NARROW + PWM_WIN
                                + TICKS_PER_US * TIMER_K + 200;
    localparam logic [31:0] RAM_BYTES = 4 * `RV_DMEM_WORDS;
    localparam logic [31:0] LEDS_BYTE = {`RV_LEDS_ADDR, 2'b00};
    localparam logic [31:0] MICROS_BYTE = {`RV_MICROS_ADDR, 2'b00};

    logic                     clk = 1'b0;
    logic                     rst_n;
    mem_access_pkg::mem_req_t req;
    logic [31:0]              rdata;
    periph_pkg::pwm_out_t     pwm;

    int                       seed;
    int                       errors;
    int                       cycle_cnt = 0;
    logic [7:0]               shadow [4096];
    periph_pkg::led_duty_t    led_shadow;
    logic                     chk_en, pend_en, pwm_chk, leds_zero;
    logic [31:0]              chk_exp, pend_exp;
    periph_pkg::led_duty_t    pwm_high, pwm_exp;

    rv_data_mem u_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .rdata (rdata),
        .pwm   (pwm)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Load data is checked one cycle after its request
    a_rdata: assert property (@(posedge clk) disable iff (!rst_n) chk_en |-> rdata == chk_exp)
        else begin
            errors++;
            $display("Mismatch at %0t: rdata expected %h, actual %h",
                     $time, $sampled(chk_exp), $sampled(rdata));
        end

    a_pwm_duty: assert property (@(posedge clk) disable iff (!rst_n)
        pwm_chk |-> pwm_high == pwm_exp)
        else begin
            errors++;
            $display("Mismatch at %0t: pwm high cycles expected %h, actual %h",
                     $time, $sampled(pwm_exp), $sampled(pwm_high));
        end

    a_pwm_idle: assert property (@(posedge clk) disable iff (!rst_n)
        leds_zero |-> pwm == 4'b0000)
        else begin
            errors++;
            $display("Mismatch at %0t: pwm expected 0000, actual %b", $time, $sampled(pwm));
        end

    function automatic mem_access_pkg::mem_req_t make_req(input logic we,
            input mem_access_pkg::mem_funct3_e f3, input logic [31:0] addr,
            input logic [31:0] data);
        return '{we, f3, addr, data};
    endfunction

    // Whole word as the rules define it, zero outside RAM and the LED register
    function automatic logic [31:0] word_model(input logic [31:0] addr);
        if (addr < RAM_BYTES) begin
            return {shadow[{addr[11:2], 2'd3}], shadow[{addr[11:2], 2'd2}],
                    shadow[{addr[11:2], 2'd1}], shadow[{addr[11:2], 2'd0}]};
        end else if (addr[31:2] == LEDS_BYTE[31:2]) begin
            return led_shadow;
        end
        return 32'd0;
    endfunction

    function automatic logic [31:0] load_model(input logic [31:0] addr,
            input mem_access_pkg::mem_funct3_e f3);
        logic [31:0] w;
        logic [15:0] h;
        logic [7:0]  b;
        w = word_model(addr);
        h = addr[1] ? w[31:16] : w[15:0];
        b = w[8*addr[1:0] +: 8];
        case (f3)
            mem_access_pkg::F3_BYTE:   return {{24{b[7]}}, b};
            mem_access_pkg::F3_BYTE_U: return {24'd0, b};
            mem_access_pkg::F3_HALF:   return {{16{h[15]}}, h};
            mem_access_pkg::F3_HALF_U: return {16'd0, h};
            default:                   return w;
        endcase
    endfunction

    // Drives one request and hands the previous request's check to the assertion
    task automatic issue(input mem_access_pkg::mem_req_t r, input logic check,
                         input logic [31:0] exp);
        @(posedge clk);
        #1;
        chk_en   = pend_en;
        chk_exp  = pend_exp;
        req      = r;
        pend_en  = check;
        pend_exp = exp;
    endtask

    task automatic idle_cycle();
        issue(make_req(1'b0, mem_access_pkg::F3_WORD, 32'd0, 32'd0), 1'b0, 32'd0);
    endtask

    task automatic store(input logic [31:0] addr, input mem_access_pkg::mem_funct3_e f3,
                         input logic [31:0] data);
        logic [31:0] w;
        w = word_model(addr);
        case (f3)
            mem_access_pkg::F3_WORD: w = data;
            mem_access_pkg::F3_HALF: w[16*addr[1] +: 16] = data[15:0];
            default:                 w[8*addr[1:0] +: 8] = data[7:0];
        endcase
        if (addr < RAM_BYTES) begin
            for (int i = 0; i < 4; i++) begin
                shadow[{addr[11:2], 2'(i)}] = w[8*i +: 8];
            end
        end else if (addr[31:2] == LEDS_BYTE[31:2]) begin
            led_shadow = w;
        end
        issue(make_req(1'b1, f3, addr, data), 1'b0, 32'd0);
    endtask

    task automatic load(input logic [31:0] addr, input mem_access_pkg::mem_funct3_e f3);
        issue(make_req(1'b0, f3, addr, 32'd0), 1'b1, load_model(addr, f3));
    endtask

    task automatic load_all_fields(input logic [31:0] base);
        for (int off = 0; off < 4; off++) begin
            load(base + off, mem_access_pkg::F3_BYTE);
            load(base + off, mem_access_pkg::F3_BYTE_U);
        end
        for (int off = 0; off < 4; off += 2) begin
            load(base + off, mem_access_pkg::F3_HALF);
            load(base + off, mem_access_pkg::F3_HALF_U);
        end
    endtask

    initial begin
        wait (cycle_cnt >= MAX_CYCLES);
        $display("Run timed out after %0d cycles", cycle_cnt);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] t0;
        seed = 843;
        errors = 0;
        {chk_en, pend_en, pwm_chk} = 3'b000;
        chk_exp = 32'd0;
        pend_exp = 32'd0;
        pwm_high = '0;
        pwm_exp = '0;
        leds_zero = 1'b1;
        led_shadow = '0;
        rst_n = 1'b0;
        req = make_req(1'b0, mem_access_pkg::F3_WORD, 32'd0, 32'd0);
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        repeat (N_WORD) begin
            addr = {20'd0, 10'($random(seed)), 2'b00};
            store(addr, mem_access_pkg::F3_WORD, $random(seed));
            load(addr, mem_access_pkg::F3_WORD);
        end

        // Each word is written whole first so the merged value is fully known
        for (int i = 0; i < N_NARROW; i++) begin
            addr = {20'd0, 10'($random(seed)), 2'b00};
            store(addr, mem_access_pkg::F3_WORD, $random(seed));
            store(addr + (i % 4), mem_access_pkg::F3_BYTE, $random(seed));
            load(addr, mem_access_pkg::F3_WORD);
            store(addr + 2 * ((i / 4) % 2), mem_access_pkg::F3_HALF, $random(seed));
            load(addr, mem_access_pkg::F3_WORD);
            load_all_fields(addr);
        end

        // The RAM words at 0x014, 0xFF4 and 0xFF8 share their low address bits with
        // the unmapped and timer writes below
        store(32'h0000_0014, mem_access_pkg::F3_WORD, 32'hA5A5_5A5A);
        store(32'h0000_0FF4, mem_access_pkg::F3_WORD, 32'h0BAD_F00D);
        store(32'h0000_0FF8, mem_access_pkg::F3_WORD, 32'h600D_CAFE);

        // Unmapped space and the timer take no writes
        store(32'h0000_1014, mem_access_pkg::F3_WORD, 32'hFFFF_FFFF);
        store(MICROS_BYTE, mem_access_pkg::F3_WORD, 32'h1234_5678);
        store(32'hFFFF_FFF8, mem_access_pkg::F3_HALF, 32'h0000_BEEF);
        load(32'h0000_0014, mem_access_pkg::F3_WORD);
        load(32'h0000_0FF4, mem_access_pkg::F3_WORD);
        load(32'h0000_0FF8, mem_access_pkg::F3_WORD);
        load(32'h0000_1014, mem_access_pkg::F3_WORD);
        load(32'h8000_0000, mem_access_pkg::F3_BYTE);
        load(32'hFFFF_FFF8, mem_access_pkg::F3_WORD);
        load(32'hFFFF_FFF0, mem_access_pkg::F3_HALF);
        load(LEDS_BYTE, mem_access_pkg::F3_WORD);

        leds_zero = 1'b0;
        store(LEDS_BYTE, mem_access_pkg::F3_WORD, 32'hC0FF_0155);
        load(LEDS_BYTE, mem_access_pkg::F3_WORD);
        store(LEDS_BYTE + 1, mem_access_pkg::F3_BYTE, 32'h0000_007A);
        store(LEDS_BYTE + 2, mem_access_pkg::F3_HALF, 32'h0000_FF03);
        store(LEDS_BYTE, mem_access_pkg::F3_BYTE, 32'h0000_0000);
        load(LEDS_BYTE, mem_access_pkg::F3_WORD);
        load(LEDS_BYTE + 3, mem_access_pkg::F3_BYTE);
        load(LEDS_BYTE + 2, mem_access_pkg::F3_HALF_U);

        // One full counter period gives each output exactly its duty in high cycles
        repeat (PWM_WIN) begin
            idle_cycle();
            pwm_high.led   = pwm_high.led + pwm.led;
            pwm_high.red   = pwm_high.red + pwm.red;
            pwm_high.green = pwm_high.green + pwm.green;
            pwm_high.blue  = pwm_high.blue + pwm.blue;
        end
        pwm_exp = led_shadow;
        pwm_chk = 1'b1;
        idle_cycle();
        pwm_chk = 1'b0;

        issue(make_req(1'b0, mem_access_pkg::F3_WORD, MICROS_BYTE, 32'd0), 1'b0, 32'd0);
        idle_cycle();
        t0 = rdata;
        repeat (TICKS_PER_US * TIMER_K - 2) idle_cycle();
        issue(make_req(1'b0, mem_access_pkg::F3_WORD, MICROS_BYTE, 32'd0), 1'b1,
              t0 + TIMER_K);
        idle_cycle();
        idle_cycle();
        @(posedge clk);
        #1;

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rv_data_mem.f */
+incdir+hdl
hdl/mem_access_pkg.sv
hdl/periph_pkg.sv
hdl/store_align.sv
hdl/byte_lane_ram.sv
hdl/periph_regs.sv
hdl/load_extend.sv
hdl/rv_data_mem.sv
verif/rv_data_mem_tb.sv

/* Bender.yml */
package:
  name: rv_data_mem

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mem_access_pkg.sv
      - hdl/periph_pkg.sv
      - hdl/store_align.sv
      - hdl/byte_lane_ram.sv
      - hdl/periph_regs.sv
      - hdl/load_extend.sv
      - hdl/rv_data_mem.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/rv_data_mem_tb.sv
